/* vlog.f */
logic/aqp_pkg.sv
logic/bus_sync.sv
logic/bank_decode.sv
logic/io_regs.sv
logic/kb_fifo.sv
logic/pwm_dac.sv
logic/aqp_top.sv
dv/aqp_sva.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

/* dv/aqp_trace.txt */
# op and hex fields: W port data | R port data oe | M addr wr ba ram_ce_n cart_ce_n ram_we_n
# K first count | Q first count | S cas_in prn_in | P cas_out prn_out | A high_count
M 0000 0 00 1 1 1
W F0 E1
W F1 10
W F2 A3
W F3 25
R F0 E1 1
R F1 10 1
R F2 A3 1
R F3 25 1
M 0100 0 01 0 1 1
M 0100 1 01 0 1 1
M 3900 1 01 0 1 0
M 4000 1 10 1 0 1
M B800 1 03 0 1 1
M C000 1 05 0 1 0
W FB 01
W F3 55
R F3 00 0
R FB 01 1
W FB 00
R F3 25 1
S 1 0
R FC 00 1
R FE 00 1
S 0 1
R FC 01 1
R FE 01 1
W FC 01
W FE 01
P 1 1
R FA 00 1
K 30 3
Q 30 3
R FA 00 1
K 40 5
W FA 00
R FA 00 1
K 50 11
Q 50 10
R FA 00 1
W EC 40
A 07FF
W FC 00
P 0 1
A 0400

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top import aqp_pkg::*; ();

    logic        clk;
    logic        reset;
    addr_t       ebus_a;
    byte_t       ebus_d_in;
    byte_t       ebus_d_out;
    logic        ebus_d_oe;
    logic        ebus_rd_n;
    logic        ebus_wr_n;
    logic        ebus_mreq_n;
    logic        ebus_iorq_n;
    logic [4:0]  ebus_ba;
    logic        ebus_ram_ce_n;
    logic        ebus_cart_ce_n;
    logic        ebus_ram_we_n;
    logic        cassette_in;
    logic        cassette_out;
    logic        printer_in;
    logic        printer_out;
    logic        kb_req;
    byte_t       kb_data;
    logic        kb_ack;
    logic        audio;

    logic [1:0]  chk_kind;
    logic [15:0] exp_val;
    logic        audio_win;
    int          mismatches;
    int          checks;
    int          failures;
    int          wd_cycles = 0;

    tb_clock   i_clock (.clk, .reset);
    aqp_top    i_dut (.*);
    tb_checker i_checker (.*);

    bind kb_fifo aqp_sva i_kb_sva (.clk, .reset, .kb_req, .kb_ack, .kb_count);

    ////////////////////////////////////////////////////////////////////////////
    // Bus and keyboard drivers
    ////////////////////////////////////////////////////////////////////////////
    task automatic bus_cycle(input logic io, input logic wr, input addr_t addr,
                             input byte_t data, input logic [1:0] kind,
                             input logic [15:0] exp);
        @(negedge clk);
        ebus_a      = addr;
        ebus_d_in   = data;
        ebus_iorq_n = !io;
        ebus_mreq_n = io;
        ebus_wr_n   = !wr;
        ebus_rd_n   = wr;
        chk_kind    = kind;         // Sampled before the read pulse pops
        exp_val     = exp;
        @(negedge clk);
        chk_kind    = 2'd0;
        repeat (7) @(negedge clk);
        ebus_iorq_n = 1'b1;
        ebus_mreq_n = 1'b1;
        ebus_wr_n   = 1'b1;
        ebus_rd_n   = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        while (kb_ack !== level && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (kb_ack !== level) begin
            failures++;
            $display("Error at time %0t: kb_ack did not go to %0b within 50 cycles",
                     $time, level);
        end
    endtask

    task automatic push_key(input byte_t data);
        @(negedge clk);
        kb_data = data;
        kb_req  = 1'b1;
        wait_for_ack(1'b1);
        kb_req  = 1'b0;
        wait_for_ack(1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Trace player
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        int          n_lines;
        int          sva_fails;
        string       line;
        byte         op;
        logic [15:0] f0, f1, f2, f3, f4, f5;

        ebus_a      = '0;
        ebus_d_in   = '0;
        ebus_rd_n   = 1'b1;
        ebus_wr_n   = 1'b1;
        ebus_mreq_n = 1'b1;
        ebus_iorq_n = 1'b1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        kb_req      = 1'b0;
        kb_data     = '0;
        chk_kind    = 2'd0;
        exp_val     = '0;
        audio_win   = 1'b0;
        failures    = 0;
        n_lines     = 0;

        fd = $fopen("dv/aqp_trace.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Error: cannot open dv/aqp_trace.txt");
        end else begin
            while ($fgets(line, fd)) n_lines++;
            $fclose(fd);
            wd_cycles = n_lines * 20000;
            fd = $fopen("dv/aqp_trace.txt", "r");
            wait (!reset);
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line[0] == "#") continue;
                void'($sscanf(line, "%c %h %h %h %h %h %h", op, f0, f1, f2, f3, f4, f5));
                case (op)
                    "W": bus_cycle(1'b1, 1'b1, f0, f1[7:0], 2'd0, '0);
                    "R": bus_cycle(1'b1, 1'b0, f0, '0, 2'd1, {7'b0, f2[0], f1[7:0]});
                    "M": bus_cycle(1'b0, f1[0], f0, '0, 2'd2,
                                   {5'b0, f5[0], f4[0], f3[0], 3'b0, f2[4:0]});
                    "K": for (int i = 0; i < f1; i++) push_key(byte_t'(f0 + i));
                    "Q": for (int i = 0; i < f1; i++) begin
                        bus_cycle(1'b1, 1'b0, addr_t'(io_kbbuf_addr), '0, 2'd1,
                                  {7'b0, 1'b1, byte_t'(f0 + i)});
                    end
                    "S": begin
                        @(negedge clk);
                        cassette_in = f0[0];
                        printer_in  = f1[0];
                        repeat (5) @(negedge clk);     // Through the synchronizers
                    end
                    "P": begin
                        @(negedge clk);
                        chk_kind = 2'd3;
                        exp_val  = {14'b0, f1[0], f0[0]};
                        @(negedge clk);
                        chk_kind = 2'd0;
                    end
                    "A": begin
                        repeat (8) @(negedge clk);     // Mix settles
                        exp_val   = f0;
                        audio_win = 1'b1;
                        repeat (16384) @(negedge clk);
                        audio_win = 1'b0;
                        repeat (2) @(negedge clk);
                    end
                    default: begin
                        failures++;
                        $display("Error: unknown trace operation in line: %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (4) @(negedge clk);
        sva_fails = i_dut.i_kb_fifo.i_kb_sva.fail_count;
        $display("Errors: %0d mismatches in %0d checks, %0d assertions, %0d other failures",
                 mismatches, checks, sva_fails, failures);
        if (mismatches == 0 && failures == 0 && sva_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles", wd_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import aqp_pkg::*; (
    input  logic        clk,
    input  logic [1:0]  chk_kind,       // 1 read, 2 memory, 3 pins
    input  logic [15:0] exp_val,
    input  logic        audio_win,
    input  byte_t       ebus_d_out,
    input  logic        ebus_d_oe,
    input  logic [4:0]  ebus_ba,
    input  logic        ebus_ram_ce_n,
    input  logic        ebus_cart_ce_n,
    input  logic        ebus_ram_we_n,
    input  logic        cassette_out,
    input  logic        printer_out,
    input  logic        audio,
    output int          mismatches,
    output int          checks
);

    int   high_count;
    logic in_window;

    initial begin
        mismatches = 0;
        checks     = 0;
        high_count = 0;
        in_window  = 1'b0;
    end

    task automatic compare(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Inputs change on the falling edge, so the rising edge sees them settled
    always @(posedge clk) begin
        case (chk_kind)
            2'd1: begin
                compare("ebus_d_out", ebus_d_out, exp_val[7:0]);
                compare("ebus_d_oe", ebus_d_oe, exp_val[8]);
            end
            2'd2: begin
                compare("ebus_ba", ebus_ba, exp_val[4:0]);
                compare("ebus_ram_ce_n", ebus_ram_ce_n, exp_val[8]);
                compare("ebus_cart_ce_n", ebus_cart_ce_n, exp_val[9]);
                compare("ebus_ram_we_n", ebus_ram_we_n, exp_val[10]);
            end
            2'd3: begin
                compare("cassette_out", cassette_out, exp_val[0]);
                compare("printer_out", printer_out, exp_val[1]);
            end
            default: ;
        endcase

        // High bits over one window, compared when it closes
        if (audio_win) begin
            high_count = high_count + audio;
            in_window  = 1'b1;
        end else if (in_window) begin
            compare("audio high count", high_count[15:0], exp_val);
            high_count = 0;
            in_window  = 1'b0;
        end
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    // Reset spans the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* dv/aqp_sva.sv */
`timescale 1ns/1ps

module aqp_sva import aqp_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                kb_req,
    input  logic                kb_ack,
    input  logic [kb_cnt_w-1:0] kb_count
);

    int fail_count = 0;     // Failed assertions so far

    // Ack only answers a request seen on the previous edge
    ack_follows_req: assert property (
        @(posedge clk) disable iff (reset) $rose(kb_ack) |-> $past(kb_req))
        else begin
            fail_count++;
            $error("kb_ack rose while kb_req was low");
        end

    count_in_range: assert property (
        @(posedge clk) disable iff (reset) kb_count <= kb_depth)
        else begin
            fail_count++;
            $error("kb_count above FIFO depth");
        end

    ack_low_in_reset: assert property (
        @(posedge clk) reset |-> !kb_ack)
        else begin
            fail_count++;
            $error("kb_ack high during reset");
        end

endmodule

/* logic/aqp_top.sv */
`timescale 1ns/1ps

module aqp_top import aqp_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Z80 bus
    input  addr_t       ebus_a,
    input  byte_t       ebus_d_in,
    output byte_t       ebus_d_out,
    output logic        ebus_d_oe,
    input  logic        ebus_rd_n,
    input  logic        ebus_wr_n,
    input  logic        ebus_mreq_n,
    input  logic        ebus_iorq_n,
    output logic [4:0]  ebus_ba,
    output logic        ebus_ram_ce_n,
    output logic        ebus_cart_ce_n,
    output logic        ebus_ram_we_n,

    // Cassette and printer
    input  logic        cassette_in,
    output logic        cassette_out,
    input  logic        printer_in,
    output logic        printer_out,

    // Keyboard byte stream
    input  logic        kb_req,
    input  byte_t       kb_data,
    output logic        kb_ack,

    output logic        audio
);

    logic                rd_pulse;
    logic                wr_pulse;
    logic                cassette_sync;
    logic                printer_sync;

    byte_t [3:0]         bank_regs;
    logic                dis_regs;
    logic                sel_dac;
    logic [3:0]          sel_bank;
    logic                sel_kbbuf;
    logic                sel_sysctrl;
    logic                sel_cassette;
    logic                sel_printer;

    logic                kb_pop;
    logic                kb_flush;
    byte_t               kb_head;
    logic [kb_cnt_w-1:0] kb_count;
    byte_t               dac_level;

    bus_sync i_bus_sync (
        .clk, .reset,
        .ebus_rd_n, .ebus_wr_n, .cassette_in, .printer_in,
        .rd_pulse, .wr_pulse, .cassette_sync, .printer_sync);

    bank_decode i_bank_decode (
        .ebus_a, .ebus_mreq_n, .ebus_iorq_n, .ebus_wr_n, .bank_regs, .dis_regs,
        .ebus_ba, .ebus_ram_ce_n, .ebus_cart_ce_n, .ebus_ram_we_n,
        .sel_dac, .sel_bank, .sel_kbbuf, .sel_sysctrl, .sel_cassette, .sel_printer);

    io_regs i_io_regs (
        .clk, .reset,
        .ebus_a, .ebus_d_in, .ebus_rd_n, .ebus_wr_n, .wr_pulse, .rd_pulse,
        .sel_dac, .sel_bank, .sel_kbbuf, .sel_sysctrl, .sel_cassette, .sel_printer,
        .cassette_sync, .printer_sync, .kb_head, .kb_count,
        .bank_regs, .dis_regs, .dac_level, .cassette_out, .printer_out,
        .kb_pop, .kb_flush, .ebus_d_out, .ebus_d_oe);

    kb_fifo i_kb_fifo (
        .clk, .reset,
        .kb_req, .kb_data, .kb_pop, .kb_flush,
        .kb_ack, .kb_head, .kb_count);

    pwm_dac i_pwm_dac (
        .clk, .reset,
        .dac_level, .cassette_out,
        .audio);

endmodule

/* logic/pwm_dac.sv */
`timescale 1ns/1ps

module pwm_dac import aqp_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  byte_t dac_level,
    input  logic  cassette_out,
    output logic  audio
);

    logic [mix_w-1:0] mix;
    logic [mix_w-1:0] acc;
    logic [mix_w:0]   sum;

    // DAC scaled by 16, beep on top
    assign mix = mix_w'({dac_level, 4'b0000})
               + (cassette_out ? mix_w'(beep_level) : '0);

    assign sum = {1'b0, acc} + {1'b0, mix};

    // First-order sigma-delta, carry out is the PWM bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc   <= '0;
            audio <= 1'b0;
        end else begin
            acc   <= sum[mix_w-1:0];
            audio <= sum[mix_w];
        end
    end

endmodule

/* logic/kb_fifo.sv */
`timescale 1ns/1ps

module kb_fifo import aqp_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                kb_req,
    input  byte_t               kb_data,
    input  logic                kb_pop,
    input  logic                kb_flush,
    output logic                kb_ack,
    output byte_t               kb_head,
    output logic [kb_cnt_w-1:0] kb_count
);

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase handshake
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic {st_idle, st_ack} hs_state_t;

    hs_state_t state;
    logic      accept;
    logic      full;
    logic      push;
    logic      pop;

    assign accept = state == st_idle && kb_req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (kb_req)  state <= st_ack;
                st_ack:  if (!kb_req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    assign kb_ack = state == st_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Circular buffer
    ////////////////////////////////////////////////////////////////////////////
    byte_t               mem [kb_depth];
    logic [kb_ptr_w-1:0] wr_ptr;
    logic [kb_ptr_w-1:0] rd_ptr;

    assign full = kb_count == kb_cnt_w'(kb_depth);
    assign push = accept && !full;       // Byte dropped when full
    assign pop  = kb_pop && kb_count != '0;

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= kb_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            kb_count <= '0;
        end else if (kb_flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            kb_count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)      kb_count <= kb_count + 1'b1;
            else if (pop && !push) kb_count <= kb_count - 1'b1;
        end
    end

    assign kb_head = mem[rd_ptr];

endmodule

/* logic/io_regs.sv */
`timescale 1ns/1ps

module io_regs import aqp_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  addr_t               ebus_a,
    input  byte_t               ebus_d_in,
    input  logic                ebus_rd_n,
    input  logic                ebus_wr_n,
    input  logic                wr_pulse,
    input  logic                rd_pulse,
    input  logic                sel_dac,
    input  logic [3:0]          sel_bank,
    input  logic                sel_kbbuf,
    input  logic                sel_sysctrl,
    input  logic                sel_cassette,
    input  logic                sel_printer,
    input  logic                cassette_sync,
    input  logic                printer_sync,
    input  byte_t               kb_head,
    input  logic [kb_cnt_w-1:0] kb_count,

    output byte_t [3:0]         bank_regs,
    output logic                dis_regs,
    output byte_t               dac_level,
    output logic                cassette_out,
    output logic                printer_out,
    output logic                kb_pop,
    output logic                kb_flush,
    output byte_t               ebus_d_out,
    output logic                ebus_d_oe
);

    byte_t wrdata;
    logic  kb_empty;
    logic  sel_internal;
    byte_t rddata;

    // Bus data latched while the write strobe is low
    always_ff @(posedge clk) begin
        if (!ebus_wr_n) wrdata <= ebus_d_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_regs    <= '0;
            dis_regs     <= 1'b0;
            dac_level    <= '0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (wr_pulse) begin
            if (sel_dac)      dac_level                <= wrdata;
            if (|sel_bank)    bank_regs[ebus_a[1:0]]   <= wrdata;   // $F0-$F3
            if (sel_sysctrl)  dis_regs                 <= wrdata[0];
            if (sel_cassette) cassette_out             <= wrdata[0];
            if (sel_printer)  printer_out              <= wrdata[0];
        end
    end

    assign kb_empty = kb_count == '0;
    assign kb_flush = sel_kbbuf && wr_pulse;
    assign kb_pop   = sel_kbbuf && rd_pulse && !kb_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rddata = '0;
        if (|sel_bank)    rddata = bank_regs[ebus_a[1:0]];
        if (sel_kbbuf)    rddata = kb_empty ? 8'h00 : kb_head;
        if (sel_sysctrl)  rddata = {7'b0, dis_regs};
        if (sel_cassette) rddata = {7'b0, !cassette_sync};   // Inverted input
        if (sel_printer)  rddata = {7'b0, printer_sync};
    end

    // DAC is write-only and never drives the bus
    assign sel_internal = |sel_bank | sel_kbbuf | sel_sysctrl | sel_cassette | sel_printer;

    assign ebus_d_out = rddata;
    assign ebus_d_oe  = !ebus_rd_n && sel_internal;

endmodule

/* logic/bank_decode.sv */
`timescale 1ns/1ps

module bank_decode import aqp_pkg::*; (
    input  addr_t       ebus_a,
    input  logic        ebus_mreq_n,
    input  logic        ebus_iorq_n,
    input  logic        ebus_wr_n,
    input  byte_t [3:0] bank_regs,
    input  logic        dis_regs,

    output logic [4:0]  ebus_ba,
    output logic        ebus_ram_ce_n,
    output logic        ebus_cart_ce_n,
    output logic        ebus_ram_we_n,

    output logic        sel_dac,
    output logic [3:0]  sel_bank,
    output logic        sel_kbbuf,
    output logic        sel_sysctrl,
    output logic        sel_cassette,
    output logic        sel_printer
);

    ////////////////////////////////////////////////////////////////////////////
    // Memory banking
    ////////////////////////////////////////////////////////////////////////////
    byte_t bank_reg;
    page_t page;
    logic  bank_ro;
    logic  bank_overlay;
    logic  sel_sysram;
    logic  sel_ram;
    logic  sel_cart;

    // Each 16 KB window picks its own bank register
    assign bank_reg     = bank_regs[ebus_a[15:14]];
    assign page         = bank_reg[5:0];
    assign bank_ro      = bank_reg[bank_ro_bit];
    assign bank_overlay = bank_reg[bank_overlay_bit];

    // $3800-$3FFF stays writable in an overlaid bank
    assign sel_sysram = bank_overlay && ebus_a[13:11] == sysram_hi;

    assign sel_ram  = !ebus_mreq_n && page[page_ram_bit];                 // Pages 32-63
    assign sel_cart = !ebus_mreq_n && page[5:2] == page_cart_base[5:2];   // Pages 16-19

    assign ebus_ba        = page[4:0];
    assign ebus_ram_ce_n  = !sel_ram;
    assign ebus_cart_ce_n = !sel_cart;
    assign ebus_ram_we_n  = !(sel_ram && !ebus_wr_n && (!bank_ro || sel_sysram));

    ////////////////////////////////////////////////////////////////////////////
    // I/O decoding
    ////////////////////////////////////////////////////////////////////////////
    logic  sel_io;
    byte_t io_addr;

    assign sel_io  = !ebus_iorq_n;
    assign io_addr = ebus_a[7:0];

    // Maskable by the disable-registers bit
    assign sel_dac = !dis_regs && sel_io && io_addr == io_dac_addr;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            sel_bank[i] = !dis_regs && sel_io && io_addr == byte_t'(io_bank0_addr + i);
        end
    end

    // Always reachable, so software can re-enable the registers
    assign sel_kbbuf    = sel_io && io_addr == io_kbbuf_addr;
    assign sel_sysctrl  = sel_io && io_addr == io_sysctrl_addr;
    assign sel_cassette = sel_io && io_addr == io_cassette_addr;
    assign sel_printer  = sel_io && io_addr == io_printer_addr;

endmodule

/* logic/bus_sync.sv */
`timescale 1ns/1ps

module bus_sync (
    input  logic clk,
    input  logic reset,
    input  logic ebus_rd_n,
    input  logic ebus_wr_n,
    input  logic cassette_in,
    input  logic printer_in,
    output logic rd_pulse,
    output logic wr_pulse,
    output logic cassette_sync,
    output logic printer_sync
);

    logic [2:0] q_rd_n;
    logic [2:0] q_wr_n;
    logic [2:0] q_cassette;
    logic [2:0] q_printer;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_rd_n     <= 3'b111;   // Strobes idle high
            q_wr_n     <= 3'b111;
            q_cassette <= 3'b000;
            q_printer  <= 3'b000;
        end else begin
            q_rd_n     <= {q_rd_n[1:0], ebus_rd_n};
            q_wr_n     <= {q_wr_n[1:0], ebus_wr_n};
            q_cassette <= {q_cassette[1:0], cassette_in};
            q_printer  <= {q_printer[1:0], printer_in};
        end
    end

    // Falling edge seen between the two oldest stages
    assign rd_pulse = q_rd_n[2:1] == 2'b10;
    assign wr_pulse = q_wr_n[2:1] == 2'b10;

    assign cassette_sync = q_cassette[2];
    assign printer_sync  = q_printer[2];

endmodule

/* logic/aqp_pkg.sv */
package aqp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [5:0]  page_t;                // 16 KB page number

    ////////////////////////////////////////////////////////////////////////////
    // I/O port map
    ////////////////////////////////////////////////////////////////////////////
    localparam byte_t io_dac_addr      = 8'hEC; // Write only
    localparam byte_t io_bank0_addr    = 8'hF0; // Banks at $F0-$F3
    localparam byte_t io_kbbuf_addr    = 8'hFA;
    localparam byte_t io_sysctrl_addr  = 8'hFB;
    localparam byte_t io_cassette_addr = 8'hFC;
    localparam byte_t io_printer_addr  = 8'hFE;

    ////////////////////////////////////////////////////////////////////////////
    // Bank register layout and page map
    ////////////////////////////////////////////////////////////////////////////
    localparam int bank_ro_bit      = 7;
    localparam int bank_overlay_bit = 6;
    localparam int page_ram_bit     = 5;        // Pages 32-63 are RAM

    localparam page_t page_cart_base = 6'd16;   // Cartridge on pages 16-19

    // Address bits 13:11 of the $3800-$3FFF system RAM window
    localparam logic [2:0] sysram_hi = 3'd7;

    ////////////////////////////////////////////////////////////////////////////
    // Keyboard buffer and audio
    ////////////////////////////////////////////////////////////////////////////
    localparam int kb_depth = 16;
    localparam int kb_ptr_w = $clog2(kb_depth);
    localparam int kb_cnt_w = $clog2(kb_depth + 1);

    localparam int mix_w      = 14;
    localparam int beep_level = 1023;           // Cassette beep amplitude

endpackage
